/* common/espi_rx_cfg.svh */
`ifndef ESPI_RX_CFG_SVH
`define ESPI_RX_CFG_SVH

// --------------------
// link geometry
// --------------------

// bits per byte on the serial link
`define ESPI_BYTE_W 8

// depth of the rolling header and data arrays
`define ESPI_HDR_DEPTH 4
`define ESPI_DATA_DEPTH 4

// --------------------
// field widths
// --------------------

`define ESPI_ADDR_W 64
`define ESPI_LEN_W 7

// byte counts as delivered by the command decoder
`define ESPI_HDR_LEN_W 4
`define ESPI_DATA_LEN_W 7

`endif

/* common/espi_rx_pkg.sv */
`include "espi_rx_cfg.svh"

`default_nettype none

package espi_rx_pkg;

    // phase the current byte belongs to
    typedef enum logic [2:0] {
        ph_idle      = 3'd0,
        ph_command   = 3'd1,
        ph_cycletype = 3'd2,
        ph_header    = 3'd3,
        ph_data      = 3'd4,
        ph_crc       = 3'd5
    } rx_phase_e;

    typedef logic [`ESPI_BYTE_W-1:0] byte_t;

    // slot 0 sits at the low end of the packed vector
    typedef logic [`ESPI_HDR_DEPTH-1:0][`ESPI_BYTE_W-1:0]  hdr_array_t;
    typedef logic [`ESPI_DATA_DEPTH-1:0][`ESPI_BYTE_W-1:0] data_array_t;

    typedef logic [`ESPI_ADDR_W-1:0] addr_t;
    typedef logic [`ESPI_LEN_W-1:0]  len_t;

    typedef logic [$clog2(`ESPI_HDR_DEPTH)-1:0]  hdr_idx_t;
    typedef logic [$clog2(`ESPI_DATA_DEPTH)-1:0] data_idx_t;

    typedef logic [`ESPI_HDR_LEN_W-1:0] hdr_cnt_t;

endpackage

`default_nettype wire

/* common/espi_rx_phase_if.sv */
`default_nettype none

// phase and array slot of the byte on the link
interface espi_rx_phase_if;

    import espi_rx_pkg::*;

    rx_phase_e phase;
    hdr_idx_t  hdr_idx;
    hdr_cnt_t  hdr_pos;
    data_idx_t data_idx;

    modport sequencer (
        output phase,
        output hdr_idx,
        output hdr_pos,
        output data_idx
    );

    modport capture (
        input phase,
        input hdr_idx,
        input hdr_pos,
        input data_idx
    );

endinterface

`default_nettype wire

/* hw/espi_rx_sequencer.sv */
`include "espi_rx_cfg.svh"

`default_nettype none

module espi_rx_sequencer (
    input  wire logic                        clk,
    input  wire logic                        ip_reset_n,
    input  wire logic                        start,
    input  wire logic                        stop,
    input  wire logic                        byte_valid,
    input  wire logic                        with_cycletype,
    input  wire espi_rx_pkg::hdr_cnt_t       hdr_len,
    input  wire logic [`ESPI_DATA_LEN_W-1:0] data_len,
    output logic                             frame_done,
    output logic                             rx_idle,
    espi_rx_phase_if.sequencer               phase_if
);

    import espi_rx_pkg::*;

    rx_phase_e                   phase;
    rx_phase_e                   phase_nxt;
    logic                        accept;
    hdr_cnt_t                    hdr_pos;
    hdr_cnt_t                    hdr_wrap;
    hdr_idx_t                    hdr_idx;
    logic                        hdr_last;
    logic [`ESPI_DATA_LEN_W-1:0] data_pos;
    logic [`ESPI_DATA_LEN_W-1:0] data_wrap;
    data_idx_t                   data_idx;
    logic                        data_last;

    // a byte only counts while a frame is open
    assign accept = byte_valid && (phase != ph_idle);

    assign hdr_last  = (hdr_pos == hdr_len - 1'b1);
    assign data_last = (data_pos == data_len - 1'b1);

    // array slots wrap at the smaller of frame length and depth
    assign hdr_wrap  = (hdr_len > `ESPI_HDR_DEPTH) ? hdr_cnt_t'(`ESPI_HDR_DEPTH) : hdr_len;
    assign data_wrap = (data_len > `ESPI_DATA_DEPTH) ?
                       `ESPI_DATA_LEN_W'(`ESPI_DATA_DEPTH) : data_len;

    // --------------------
    // phase FSM
    // --------------------

    always_comb begin
        phase_nxt = phase;
        if (stop) begin
            phase_nxt = ph_idle;
        end else if (phase == ph_idle) begin
            if (start) begin
                phase_nxt = ph_command;
            end
        end else if (accept) begin
            case (phase)
                ph_command: begin
                    if (with_cycletype) begin
                        phase_nxt = ph_cycletype;
                    end else if (hdr_len != '0) begin
                        phase_nxt = ph_header;
                    end else begin
                        phase_nxt = ph_crc;
                    end
                end
                ph_cycletype: phase_nxt = ph_header;
                ph_header: begin
                    if (hdr_last) begin
                        phase_nxt = (data_len != '0) ? ph_data : ph_crc;
                    end
                end
                ph_data: begin
                    if (data_last) begin
                        phase_nxt = ph_crc;
                    end
                end
                // crc byte is mandatory and closes the frame
                ph_crc: phase_nxt = ph_idle;
                default: phase_nxt = ph_idle;
            endcase
        end
    end

    always_ff @(posedge clk or negedge ip_reset_n) begin
        if (!ip_reset_n) begin
            phase <= ph_idle;
        end else begin
            phase <= phase_nxt;
        end
    end

    // --------------------
    // byte counters
    // --------------------

    always_ff @(posedge clk or negedge ip_reset_n) begin
        if (!ip_reset_n) begin
            hdr_pos <= '0;
            hdr_idx <= '0;
        end else if (phase == ph_command) begin
            hdr_pos <= '0;
            hdr_idx <= '0;
        end else if (accept && !stop && (phase == ph_header)) begin
            hdr_pos <= hdr_last ? '0 : hdr_pos + 1'b1;
            hdr_idx <= (hdr_cnt_t'(hdr_idx) == hdr_wrap - 1'b1) ? '0 : hdr_idx + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge ip_reset_n) begin
        if (!ip_reset_n) begin
            data_pos <= '0;
            data_idx <= '0;
        end else if (phase == ph_command) begin
            data_pos <= '0;
            data_idx <= '0;
        end else if (accept && !stop && (phase == ph_data)) begin
            data_pos <= data_last ? '0 : data_pos + 1'b1;
            data_idx <= (`ESPI_DATA_LEN_W'(data_idx) == data_wrap - 1'b1) ?
                        '0 : data_idx + 1'b1;
        end
    end

    // one cycle pulse once the crc byte is taken
    always_ff @(posedge clk or negedge ip_reset_n) begin
        if (!ip_reset_n) begin
            frame_done <= 1'b0;
        end else begin
            frame_done <= accept && !stop && (phase == ph_crc);
        end
    end

    assign rx_idle = (phase == ph_idle);

    assign phase_if.phase    = phase;
    assign phase_if.hdr_idx  = hdr_idx;
    assign phase_if.hdr_pos  = hdr_pos;
    assign phase_if.data_idx = data_idx;

endmodule

`default_nettype wire

/* hw/espi_rx_capture.sv */
`include "espi_rx_cfg.svh"

`default_nettype none

module espi_rx_capture (
    input  wire logic                clk,
    input  wire logic                ip_reset_n,
    input  wire logic                stop,
    input  wire logic                byte_valid,
    input  wire espi_rx_pkg::byte_t  byte_data,
    espi_rx_phase_if.capture         phase_if,
    output espi_rx_pkg::byte_t       command_byte,
    output logic [4:0]               cycletype,
    output logic [2:0]               cycletype_msb,
    output espi_rx_pkg::hdr_array_t  header_bytes,
    output espi_rx_pkg::addr_t       address,
    output espi_rx_pkg::len_t        length,
    output espi_rx_pkg::data_array_t data_bytes,
    output espi_rx_pkg::byte_t       crc_byte
);

    import espi_rx_pkg::*;

    logic accept;
    logic len_byte;

    assign accept = byte_valid && (phase_if.phase != ph_idle);

    // header bytes 1 and 2 carry the length, not address
    assign len_byte = (phase_if.hdr_pos == hdr_cnt_t'(1)) ||
                      (phase_if.hdr_pos == hdr_cnt_t'(2));

    // --------------------
    // single byte fields
    // --------------------

    always_ff @(posedge clk or negedge ip_reset_n) begin
        if (!ip_reset_n) begin
            command_byte  <= '0;
            cycletype     <= '0;
            cycletype_msb <= '0;
            crc_byte      <= '0;
        end else if (stop) begin
            command_byte  <= '0;
            cycletype     <= '0;
            cycletype_msb <= '0;
            crc_byte      <= '0;
        end else if (accept) begin
            case (phase_if.phase)
                ph_command: command_byte <= byte_data;
                ph_cycletype: begin
                    cycletype     <= byte_data[4:0];
                    cycletype_msb <= byte_data[7:5];
                end
                ph_crc: crc_byte <= byte_data;
                default: ;
            endcase
        end
    end

    // --------------------
    // header, length, address
    // --------------------

    always_ff @(posedge clk or negedge ip_reset_n) begin
        if (!ip_reset_n) begin
            header_bytes <= '0;
            length       <= '0;
            address      <= '0;
        end else if (stop) begin
            header_bytes <= '0;
            length       <= '0;
            address      <= '0;
        end else if (accept && (phase_if.phase == ph_header)) begin
            header_bytes[phase_if.hdr_idx] <= byte_data;
            if (phase_if.hdr_pos == hdr_cnt_t'(2)) begin
                length <= byte_data[`ESPI_LEN_W-1:0];
            end
            // address bytes arrive msb first
            if (!len_byte) begin
                address <= {address[`ESPI_ADDR_W-`ESPI_BYTE_W-1:0], byte_data};
            end
        end
    end

    // rolling data array
    always_ff @(posedge clk or negedge ip_reset_n) begin
        if (!ip_reset_n) begin
            data_bytes <= '0;
        end else if (stop) begin
            data_bytes <= '0;
        end else if (accept && (phase_if.phase == ph_data)) begin
            data_bytes[phase_if.data_idx] <= byte_data;
        end
    end

endmodule

`default_nettype wire

/* hw/espi_rx_frame.sv */
`include "espi_rx_cfg.svh"

`default_nettype none

module espi_rx_frame (
    input  wire logic                        clk,
    input  wire logic                        ip_reset_n,
    input  wire logic                        start,
    input  wire logic                        stop,
    input  wire logic                        byte_valid,
    input  wire espi_rx_pkg::byte_t          byte_data,
    input  wire logic                        with_cycletype,
    input  wire espi_rx_pkg::hdr_cnt_t       hdr_len,
    input  wire logic [`ESPI_DATA_LEN_W-1:0] data_len,
    output logic                             frame_done,
    output logic                             rx_idle,
    output espi_rx_pkg::byte_t               command_byte,
    output logic [4:0]                       cycletype,
    output logic [2:0]                       cycletype_msb,
    output espi_rx_pkg::hdr_array_t          header_bytes,
    output espi_rx_pkg::addr_t               address,
    output espi_rx_pkg::len_t                length,
    output espi_rx_pkg::data_array_t         data_bytes,
    output espi_rx_pkg::byte_t               crc_byte
);

    // phase and slot of each byte, sequencer to capture
    espi_rx_phase_if phase_if ();

    espi_rx_sequencer i_sequencer (
        .clk            (clk),
        .ip_reset_n     (ip_reset_n),
        .start          (start),
        .stop           (stop),
        .byte_valid     (byte_valid),
        .with_cycletype (with_cycletype),
        .hdr_len        (hdr_len),
        .data_len       (data_len),
        .frame_done     (frame_done),
        .rx_idle        (rx_idle),
        .phase_if       (phase_if.sequencer)
    );

    espi_rx_capture i_capture (
        .clk           (clk),
        .ip_reset_n    (ip_reset_n),
        .stop          (stop),
        .byte_valid    (byte_valid),
        .byte_data     (byte_data),
        .phase_if      (phase_if.capture),
        .command_byte  (command_byte),
        .cycletype     (cycletype),
        .cycletype_msb (cycletype_msb),
        .header_bytes  (header_bytes),
        .address       (address),
        .length        (length),
        .data_bytes    (data_bytes),
        .crc_byte      (crc_byte)
    );

endmodule

`default_nettype wire

/* testbench/tb_clock_gen.sv */
`default_nettype none

// free running clock and power-on reset for the testbench
module tb_clock_gen #(
    parameter int reset_cycles = 4
) (
    output logic clk,
    output logic ip_reset_n
);

    timeunit 1ns;
    timeprecision 1ps;

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // release on a falling edge away from the sampling edge
    initial begin
        ip_reset_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        ip_reset_n = 1'b1;
    end

endmodule

`default_nettype wire

/* testbench/tb_espi_rx_frame.sv */
`include "espi_rx_cfg.svh"

`default_nettype none

module tb_espi_rx_frame;

    timeunit 1ns;
    timeprecision 1ps;

    import espi_rx_pkg::*;

    localparam int num_frames = 7;
    localparam int max_bytes  = 12;
    localparam int max_gap    = 6;
    // every frame at its longest with the widest gaps, plus setup cycles and margin
    localparam int timeout_cycles = num_frames * (max_bytes * (max_gap + 1) + 8) + 40;

    // one table row with the first byte leftmost in bytes
    // stop_at of 15 means the frame runs to its end
    typedef struct packed {
        logic                        with_cycletype;
        hdr_cnt_t                    hdr_len;
        logic [`ESPI_DATA_LEN_W-1:0] data_len;
        logic [3:0]                  num_bytes;
        logic [3:0]                  max_gap;
        logic [3:0]                  stop_at;
        logic [8*max_bytes-1:0]      bytes;
        byte_t                       exp_command;
        logic [4:0]                  exp_cycletype;
        logic [2:0]                  exp_msb;
        hdr_array_t                  exp_header;
        addr_t                       exp_address;
        len_t                        exp_length;
        data_array_t                 exp_data;
        byte_t                       exp_crc;
        logic                        exp_done;
    } frame_t;

    logic clk;
    logic ip_reset_n;
    logic start;
    logic stop;
    logic byte_valid;
    byte_t byte_data;
    logic with_cycletype;
    hdr_cnt_t hdr_len;
    logic [`ESPI_DATA_LEN_W-1:0] data_len;
    logic frame_done;
    logic rx_idle;
    byte_t command_byte;
    logic [4:0] cycletype;
    logic [2:0] cycletype_msb;
    hdr_array_t header_bytes;
    addr_t address;
    len_t length;
    data_array_t data_bytes;
    byte_t crc_byte;

    frame_t frames [num_frames];
    frame_t blank;
    int value_errors = 0;
    int other_errors = 0;
    int pulses = 0;
    int cycles = 0;

    tb_clock_gen i_clock_gen (
        .clk        (clk),
        .ip_reset_n (ip_reset_n)
    );

    espi_rx_frame i_dut (
        .clk            (clk),
        .ip_reset_n     (ip_reset_n),
        .start          (start),
        .stop           (stop),
        .byte_valid     (byte_valid),
        .byte_data      (byte_data),
        .with_cycletype (with_cycletype),
        .hdr_len        (hdr_len),
        .data_len       (data_len),
        .frame_done     (frame_done),
        .rx_idle        (rx_idle),
        .command_byte   (command_byte),
        .cycletype      (cycletype),
        .cycletype_msb  (cycletype_msb),
        .header_bytes   (header_bytes),
        .address        (address),
        .length         (length),
        .data_bytes     (data_bytes),
        .crc_byte       (crc_byte)
    );

    // --------------------
    // compare tasks
    // --------------------

    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_hdr_array(input string name, input hdr_array_t got,
                                   input hdr_array_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_data_array(input string name, input data_array_t got,
                                    input data_array_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_len(input string name, input len_t got, input len_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            value_errors++;
            $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_outputs(input frame_t f);
        check_byte("command_byte", command_byte, f.exp_command);
        check_byte("cycletype", byte_t'(cycletype), byte_t'(f.exp_cycletype));
        check_byte("cycletype_msb", byte_t'(cycletype_msb), byte_t'(f.exp_msb));
        check_hdr_array("header_bytes", header_bytes, f.exp_header);
        check_addr("address", address, f.exp_address);
        check_len("length", length, f.exp_length);
        check_data_array("data_bytes", data_bytes, f.exp_data);
        check_byte("crc_byte", crc_byte, f.exp_crc);
    endtask

    // --------------------
    // frame driver
    // --------------------

    task automatic run_frame(input frame_t f);
        int unsigned gap;
        // stop in idle wipes the previous frame's fields
        stop = 1'b1;
        @(negedge clk);
        stop = 1'b0;
        start = 1'b1;
        with_cycletype = f.with_cycletype;
        hdr_len = f.hdr_len;
        data_len = f.data_len;
        // a byte next to start must be dropped
        byte_valid = 1'b1;
        byte_data = 8'hff;
        @(negedge clk);
        start = 1'b0;
        byte_valid = 1'b0;
        pulses = 0;
        check_flag("rx_idle", rx_idle, 1'b0);
        for (int i = 0; i < int'(f.num_bytes); i++) begin
            gap = $urandom_range(32'(f.max_gap), 0);
            repeat (gap) begin
                byte_valid = 1'b0;
                byte_data = byte_t'($urandom);
                @(negedge clk);
            end
            byte_valid = 1'b1;
            byte_data = f.bytes[8*(max_bytes-1-i) +: 8];
            stop = (i == int'(f.stop_at));
            @(negedge clk);
            if (i == int'(f.stop_at)) begin
                break;
            end
        end
        stop = 1'b0;
        byte_valid = 1'b0;
        check_flag("frame_done", frame_done, f.exp_done);
        check_flag("rx_idle", rx_idle, 1'b1);
        check_outputs(f);
        @(negedge clk);
        check_flag("frame_done", frame_done, 1'b0);
        if (pulses != int'(f.exp_done)) begin
            other_errors++;
            $display("frame_done pulsed %0d times where %0d was expected", pulses, f.exp_done);
        end
    endtask

    // frame_done is counted before the edge updates it
    always @(posedge clk) begin
        if (frame_done) begin
            pulses++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= timeout_cycles) begin
            $display("timeout, the run went past %0d clock cycles", timeout_cycles);
            $display(">>> FAIL");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'h35da));
        start = 1'b0;
        stop = 1'b0;
        byte_valid = 1'b0;
        byte_data = '0;
        with_cycletype = 1'b0;
        hdr_len = '0;
        data_len = '0;
        blank = '0;

        // command and crc only
        frames[0] = '{1'b0, 4'd0, 7'd0, 4'd2, 4'd0, 4'hf, 96'ha53c_0000_0000_0000_0000_0000,
                      8'ha5, 5'h00, 3'h0, 32'h0, 64'h0, 7'h00, 32'h0, 8'h3c, 1'b1};
        // cycle type and six header bytes with header slots wrapping at 4
        frames[1] = '{1'b1, 4'd6, 7'd0, 4'd9, 4'd2, 4'hf, 96'h21e9_1182_4394_5566_7e00_0000,
                      8'h21, 5'h09, 3'h7, 32'h9443_6655, 64'h1194_5566, 7'h43, 32'h0,
                      8'h7e, 1'b1};
        frames[2] = '{1'b0, 4'd3, 7'd2, 4'd7, 4'd1, 4'hf, 96'h4a01_0283_d0d1_c500_0000_0000,
                      8'h4a, 5'h00, 3'h0, 32'h0083_0201, 64'h01, 7'h03, 32'h0000_d1d0,
                      8'hc5, 1'b1};
        // data slots 0 and 1 overwritten
        frames[3] = '{1'b0, 4'd1, 7'd6, 4'd9, 4'd1, 4'hf, 96'h5ba7_3132_3334_3536_e400_0000,
                      8'h5b, 5'h00, 3'h0, 32'h0000_00a7, 64'ha7, 7'h00, 32'h3433_3635,
                      8'he4, 1'b1};
        // stop with the third header byte
        frames[4] = '{1'b1, 4'd4, 7'd0, 4'd7, 4'd1, 4'd4, 96'h6612_f1f2_f3f4_9900_0000_0000,
                      8'h00, 5'h00, 3'h0, 32'h0, 64'h0, 7'h00, 32'h0, 8'h00, 1'b0};
        frames[5] = '{1'b1, 4'd3, 7'd1, 4'd7, 4'd0, 4'hf, 96'h775f_9a0b_8cee_3d00_0000_0000,
                      8'h77, 5'h1f, 3'h2, 32'h008c_0b9a, 64'h9a, 7'h0c, 32'h0000_00ee,
                      8'h3d, 1'b1};
        // long random gaps between bytes
        frames[6] = '{1'b1, 4'd5, 7'd3, 4'd11, 4'd6, 4'hf, 96'hc32a_4041_8546_47b1_b2b3_0f00,
                      8'hc3, 5'h0a, 3'h1, 32'h4685_4147, 64'h40_4647, 7'h05, 32'h00b3_b2b1,
                      8'h0f, 1'b1};

        @(posedge ip_reset_n);
        @(negedge clk);
        check_flag("rx_idle", rx_idle, 1'b1);
        check_flag("frame_done", frame_done, 1'b0);
        check_outputs(blank);

        for (int e = 0; e < num_frames; e++) begin
            run_frame(frames[e]);
        end

        $display("errors: %0d value mismatches, %0d other failures", value_errors,
                 other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* espi_rx_frame.f */
+incdir+common
common/espi_rx_pkg.sv
common/espi_rx_phase_if.sv
hw/espi_rx_sequencer.sv
hw/espi_rx_capture.sv
hw/espi_rx_frame.sv
testbench/tb_clock_gen.sv
testbench/tb_espi_rx_frame.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the espi_rx_frame testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log
top=tb_espi_rx_frame

if ! verilator --binary --timing --timescale 1ns/1ps --top-module "$top" \
        -f espi_rx_frame.f --Mdir "$build_dir"; then
    echo "verilator build failed"
    exit 1
fi

"./$build_dir/V$top" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qF ">>> FAIL" "$log_file"; then
    exit 1
fi
exit 0
